// ==== build.f ====
verilog/pifo_pkg.sv
verilog/pifo_min_select.sv
verilog/pifo_push_update.sv
verilog/pifo_pop_update.sv
verilog/pifo_level_ctrl.sv
verilog/pifo_sram_level.sv
testbench/pifo_level_sva.sv
testbench/pifo_level_checker.sv
testbench/tb_pifo_sram_level.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run with Verilator, then judge the log
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_pifo_sram_level \
    && ./obj_dir/Vtb_pifo_sram_level +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1

// ==== testbench/pifo_level_checker.sv ====
`default_nettype none

module pifo_level_checker #(
    parameter int NUM_LEVELS = 4
) (
    // Same names as the DUT ports, all observed
    input  wire                       i_clk,
    input  wire                       i_arst_n,
    input  wire                       i_push,
    input  wire pifo_pkg::elem_t      i_push_data,
    input  wire                       i_pop,
    input  wire pifo_pkg::node_addr_t i_my_addr,
    input  wire pifo_pkg::level_t     i_level,
    input  wire pifo_pkg::elem_t      o_pop_data,
    input  wire                       o_read,
    input  wire pifo_pkg::node_addr_t o_read_addr,
    input  wire pifo_pkg::node_word_t i_read_data,
    input  wire                       o_write,
    input  wire pifo_pkg::node_addr_t o_write_addr,
    input  wire pifo_pkg::node_word_t o_write_data,
    input  wire pifo_pkg::child_req_t o_child,
    input  wire pifo_pkg::elem_t      i_pop_data,
    output int                        o_errors
);

    int                     err_count = 0;
    string                  cur_test;
    pifo_pkg::level_state_e phase;      // Expected state of the level
    pifo_pkg::elem_t        elem_m;
    pifo_pkg::node_addr_t   addr_m;
    pifo_pkg::level_t       level_m;
    pifo_pkg::node_word_t   word_m;     // Node word read by the pop
    int                     slot_m;

    assign o_errors = err_count;

    task automatic check_value(input string name, input logic [255:0] exp,
                               input logic [255:0] act);
        if (exp !== act) begin
            err_count++;
            $display("** Error %s %s at %0t: expected %0h, actual %0h",
                     cur_test, name, $time, exp, act);
        end
    endtask

    // Scans downward so that ties end on the lowest index
    function automatic int first_min(input pifo_pkg::node_word_t w, input logic by_count);
        int best;
        best = pifo_pkg::SLOTS - 1;
        for (int i = pifo_pkg::SLOTS - 2; i >= 0; i--) begin
            if (by_count ? (w[i].count <= w[best].count) : (w[i].elem <= w[best].elem)) begin
                best = i;
            end
        end
        return best;
    endfunction

    // ------------------------------------------------------------------
    // Prediction and comparison, sampled mid cycle
    // ------------------------------------------------------------------
    always @(negedge i_clk) begin : model
        pifo_pkg::node_word_t exp_word;
        pifo_pkg::elem_t      exp_out;
        pifo_pkg::elem_t      fwd;
        logic                 take;
        logic                 deep;
        logic                 exp_wr;
        logic                 exp_cpush;
        logic                 exp_cpop;
        int                   s;

        if (!i_arst_n) begin
            phase    = pifo_pkg::IDLE;
            cur_test = "reset";
            check_value("strobes", 256'(4'b0),
                        256'({o_read, o_write, o_child.push, o_child.pop}));
            check_value("pop_data", 256'(pifo_pkg::elem_t'('1)), 256'(o_pop_data));
        end else begin
            cur_test  = phase.name();
            take      = (i_push != i_pop) && (phase != pifo_pkg::POP);
            deep      = int'(level_m) < NUM_LEVELS - 1;    // Last level has no child
            exp_wr    = 1'b0;
            exp_cpush = 1'b0;
            exp_cpop  = 1'b0;
            exp_out   = '1;
            exp_word  = i_read_data;
            fwd       = elem_m;
            s         = 0;
            case (phase)
                pifo_pkg::PUSH: begin
                    s      = first_min(i_read_data, 1'b1);
                    exp_wr = 1'b1;
                    exp_word[s].count = i_read_data[s].count + pifo_pkg::count_t'(1);
                    if (i_read_data[s].elem == '1) begin
                        exp_word[s].elem = elem_m;
                    end else begin
                        exp_cpush = deep;
                        if (elem_m < i_read_data[s].elem) begin
                            exp_word[s].elem = elem_m;
                            fwd              = i_read_data[s].elem;
                        end
                    end
                end
                pifo_pkg::POP: begin
                    s        = first_min(i_read_data, 1'b0);
                    exp_cpop = deep;
                    exp_out  = i_read_data[s].elem;
                    word_m   = i_read_data;
                    slot_m   = s;
                end
                pifo_pkg::WB: begin
                    s        = slot_m;
                    exp_wr   = 1'b1;
                    exp_word = word_m;
                    if (word_m[s].count != '0) begin
                        exp_word[s].count = word_m[s].count - pifo_pkg::count_t'(1);
                        exp_word[s].elem  = i_pop_data;    // Child refills the slot
                    end
                end
                default: ;
            endcase

            check_value("read_strobe", 256'(take), 256'(o_read));
            if (take) begin
                check_value("read_addr", 256'(i_my_addr), 256'(o_read_addr));
            end
            check_value("write_strobe", 256'(exp_wr), 256'(o_write));
            check_value("child_push", 256'(exp_cpush), 256'(o_child.push));
            check_value("child_pop", 256'(exp_cpop), 256'(o_child.pop));
            check_value("pop_data", 256'(exp_out), 256'(o_pop_data));
            if (exp_wr) begin
                check_value("write_addr", 256'(addr_m), 256'(o_write_addr));
                check_value("write_data", 256'(exp_word), 256'(o_write_data));
            end
            if (exp_cpush) begin
                check_value("child_elem", 256'(fwd), 256'(o_child.elem));
            end
            if (exp_cpush || exp_cpop) begin
                check_value("child_addr",
                            256'(pifo_pkg::node_addr_t'(int'(addr_m) * 8 + s)),
                            256'(o_child.addr));
                check_value("child_level", 256'(pifo_pkg::level_t'(int'(level_m) + 1)),
                            256'(o_child.level));
            end

            if (phase == pifo_pkg::POP) begin
                phase = pifo_pkg::WB;
            end else if (take) begin
                phase = i_push ? pifo_pkg::PUSH : pifo_pkg::POP;
            end else begin
                phase = pifo_pkg::IDLE;
            end
            if (take) begin
                addr_m  = i_my_addr;
                level_m = i_level;
                elem_m  = i_push ? i_push_data : elem_m;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/pifo_level_sva.sv ====
`default_nettype none

module pifo_level_sva (
    input wire i_clk,
    input wire i_arst_n,
    input wire i_push,
    input wire i_pop,
    input wire i_read,
    input wire i_write,
    input wire i_child_pop
);

    int failures = 0;

    // Both strobes together are refused
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_push && i_pop) |-> !i_read)
        else begin
            $error("SRAM read started with push and pop both high");
            failures++;
        end

    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_child_pop |=> (!i_child_pop && i_write))    // Refill write right after
        else begin
            $error("Child pop was not a single pulse followed by a write");
            failures++;
        end

    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_child_pop |-> !i_write)
        else begin
            $error("Child pop overlapped an SRAM write");
            failures++;
        end

endmodule

bind pifo_sram_level pifo_level_sva u_sva (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_push      (i_push),
    .i_pop       (i_pop),
    .i_read      (o_read),
    .i_write     (o_write),
    .i_child_pop (o_child.pop)
);

`default_nettype wire

// ==== testbench/tb_pifo_sram_level.sv ====
`default_nettype none

module tb_pifo_sram_level;

    localparam int NUM_LEVELS    = 4;
    localparam int SPACED_CMDS   = 60;
    localparam int RANDOM_CYCLES = 400;
    localparam int WRITE_TIMEOUT = 4;    // Cycles allowed from a command to its write

    logic                 i_clk;
    logic                 i_arst_n;
    logic                 i_push;
    pifo_pkg::elem_t      i_push_data;
    logic                 i_pop;
    pifo_pkg::node_addr_t i_my_addr;
    pifo_pkg::level_t     i_level;
    pifo_pkg::elem_t      o_pop_data;
    logic                 o_read;
    pifo_pkg::node_addr_t o_read_addr;
    pifo_pkg::node_word_t i_read_data;
    logic                 o_write;
    pifo_pkg::node_addr_t o_write_addr;
    pifo_pkg::node_word_t o_write_data;
    pifo_pkg::child_req_t o_child;
    pifo_pkg::elem_t      i_pop_data;
    logic                 read_seen;     // o_read in the cycle just ended
    logic                 cmd;
    logic                 timed_out;
    int                   wait_cycles;
    int                   check_errors;
    int                   total_errors;

    pifo_sram_level #(.NUM_LEVELS(NUM_LEVELS)) u_pifo_sram_level (.*);

    pifo_level_checker #(.NUM_LEVELS(NUM_LEVELS)) u_checker (.*, .o_errors(check_errors));

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // ------------------------------------------------------------------
    // SRAM and child responders
    // ------------------------------------------------------------------
    function automatic pifo_pkg::node_word_t random_word();
        pifo_pkg::node_word_t w;
        for (int i = 0; i < pifo_pkg::SLOTS; i++) begin
            w[i].count = pifo_pkg::count_t'($urandom % 4);    // Zero now and then
            w[i].elem  = ($urandom % 3 == 0) ? '1 : pifo_pkg::elem_t'($urandom % 64);
        end
        return w;
    endfunction

    task automatic next_cycle();
        @(negedge i_clk);
        read_seen = o_read;
        @(posedge i_clk);
        #2;
        if (read_seen) begin
            i_read_data = random_word();
        end else begin
            i_read_data = ~i_read_data;    // Stale data once the read cycle is over
        end
        i_pop_data = pifo_pkg::elem_t'($urandom);
    endtask

    task automatic drive_command(input logic push, input logic pop);
        i_push      = push;
        i_pop       = pop;
        i_push_data = pifo_pkg::elem_t'($urandom % 64);
        i_my_addr   = pifo_pkg::node_addr_t'($urandom);
        i_level     = pifo_pkg::level_t'($urandom);
    endtask

    initial begin
        void'($urandom(32'h09109b7c));
        i_arst_n    = 1'b0;
        i_push      = 1'b0;
        i_pop       = 1'b0;
        i_push_data = '0;
        i_my_addr   = '0;
        i_level     = '0;
        i_read_data = '1;
        i_pop_data  = '1;
        read_seen   = 1'b0;
        timed_out   = 1'b0;
        repeat (3) @(posedge i_clk);
        #2;
        i_arst_n = 1'b1;

        // One command at a time with a wait for its SRAM write
        for (int k = 0; k < SPACED_CMDS && !timed_out; k++) begin
            cmd = 1'($urandom % 2);
            drive_command(cmd, !cmd);
            next_cycle();
            drive_command(1'b0, 1'b0);
            wait_cycles = 0;
            while (!o_write && wait_cycles < WRITE_TIMEOUT) begin
                next_cycle();
                wait_cycles++;
            end
            if (!o_write) begin
                $display("Timeout: no SRAM write within %0d cycles of command %0d",
                         WRITE_TIMEOUT, k);
                timed_out = 1'b1;
            end
            next_cycle();
        end

        // Back to back traffic with both strobes and commands during POP
        if (!timed_out) begin
            repeat (RANDOM_CYCLES) begin
                drive_command(1'($urandom % 2), 1'($urandom % 2));
                next_cycle();
            end
        end
        drive_command(1'b0, 1'b0);
        repeat (3) next_cycle();

        total_errors = check_errors + u_pifo_sram_level.u_sva.failures + int'(timed_out);
        $display("Errors: %0d in checks, %0d in assertions, %0d timeouts",
                 check_errors, u_pifo_sram_level.u_sva.failures, int'(timed_out));
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/pifo_level_ctrl.sv ====
`default_nettype none

module pifo_level_ctrl #(
    parameter int NUM_LEVELS = 4
) (
    input  wire                       i_clk,
    input  wire                       i_arst_n,
    input  wire                       i_push,
    input  wire pifo_pkg::elem_t      i_push_data,
    input  wire                       i_pop,
    input  wire pifo_pkg::node_addr_t i_my_addr,
    input  wire pifo_pkg::level_t     i_level,
    input  wire pifo_pkg::node_word_t i_read_data,
    input  wire pifo_pkg::slot_idx_t  i_count_slot,
    input  wire pifo_pkg::slot_idx_t  i_prio_slot,
    input  wire pifo_pkg::node_word_t i_push_word,
    input  wire                       i_fwd_valid,
    input  wire pifo_pkg::elem_t      i_fwd_elem,
    input  wire pifo_pkg::elem_t      i_pop_elem,
    input  wire pifo_pkg::node_word_t i_pop_word,
    output pifo_pkg::node_word_t      o_sel_word,
    output pifo_pkg::elem_t           o_push_elem,
    output logic                      o_read,
    output pifo_pkg::node_addr_t      o_read_addr,
    output logic                      o_write,
    output pifo_pkg::node_addr_t      o_write_addr,
    output pifo_pkg::node_word_t      o_write_data,
    output pifo_pkg::elem_t           o_pop_data,
    output pifo_pkg::child_req_t      o_child
);

    localparam int ADDR_KEEP_W = pifo_pkg::NODE_ADDR_W - pifo_pkg::SLOT_IDX_W;

    pifo_pkg::level_state_e state_q;
    pifo_pkg::level_state_e state_d;
    logic                   accept;
    logic                   has_child;
    pifo_pkg::elem_t        elem_q;
    pifo_pkg::node_addr_t   addr_q;
    pifo_pkg::level_t       level_q;
    pifo_pkg::node_word_t   word_q;     // Node word held across WB
    pifo_pkg::slot_idx_t    slot_q;     // Slot being refilled
    pifo_pkg::slot_idx_t    child_slot;

    // ------------------------------------------------------------------
    // Command acceptance and FSM
    // ------------------------------------------------------------------
    assign accept = (i_push ^ i_pop) && (state_q != pifo_pkg::POP);

    always_comb begin
        state_d = pifo_pkg::IDLE;
        if (state_q == pifo_pkg::POP) begin
            state_d = pifo_pkg::WB;     // Refill always follows a pop
        end else if (accept) begin
            state_d = i_push ? pifo_pkg::PUSH : pifo_pkg::POP;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= pifo_pkg::IDLE;
            addr_q  <= '0;
            level_q <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                addr_q  <= i_my_addr;
                level_q <= i_level;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept && i_push) begin
            elem_q <= i_push_data;
        end
        if (state_q == pifo_pkg::POP) begin
            word_q <= i_read_data;
            slot_q <= i_prio_slot;
        end
    end

    // ------------------------------------------------------------------
    // SRAM side
    // ------------------------------------------------------------------
    assign o_sel_word   = (state_q == pifo_pkg::WB) ? word_q : i_read_data;
    assign o_push_elem  = elem_q;
    assign o_read       = accept;
    assign o_read_addr  = i_my_addr;
    assign o_write      = (state_q == pifo_pkg::PUSH) || (state_q == pifo_pkg::WB);
    assign o_write_addr = addr_q;

    always_comb begin
        case (state_q)
            pifo_pkg::PUSH: o_write_data = i_push_word;
            pifo_pkg::WB:   o_write_data = i_pop_word;
            default:        o_write_data = '0;
        endcase
    end

    assign o_pop_data = (state_q == pifo_pkg::POP) ? i_pop_elem : '1;

    // ------------------------------------------------------------------
    // Child side
    // ------------------------------------------------------------------
    assign has_child = (level_q < pifo_pkg::level_t'(NUM_LEVELS - 1));  // Last level has none

    always_comb begin
        case (state_q)
            pifo_pkg::PUSH: child_slot = i_count_slot;
            pifo_pkg::POP:  child_slot = i_prio_slot;
            pifo_pkg::WB:   child_slot = slot_q;    // Stable while the child answers
            default:        child_slot = '0;
        endcase
    end

    always_comb begin
        o_child.push  = (state_q == pifo_pkg::PUSH) && i_fwd_valid && has_child;
        o_child.pop   = (state_q == pifo_pkg::POP) && has_child;
        o_child.elem  = (state_q == pifo_pkg::PUSH) ? i_fwd_elem : '1;
        o_child.addr  = {addr_q[ADDR_KEEP_W-1:0], child_slot};  // 8 * node + slot
        o_child.level = level_q + pifo_pkg::level_t'(1);
    end

endmodule

`default_nettype wire

// ==== verilog/pifo_min_select.sv ====
`default_nettype none

module pifo_min_select (
    input  wire pifo_pkg::node_word_t i_word,
    output pifo_pkg::slot_idx_t       o_count_slot,
    output pifo_pkg::slot_idx_t       o_prio_slot
);

    pifo_pkg::count_t best_count;
    pifo_pkg::elem_t  best_elem;

    // Least sub-tree count, first slot wins on a tie
    always_comb begin
        best_count   = i_word[0].count;
        o_count_slot = '0;
        for (int i = 1; i < pifo_pkg::SLOTS; i++) begin
            if (i_word[i].count < best_count) begin
                best_count   = i_word[i].count;
                o_count_slot = pifo_pkg::slot_idx_t'(i);
            end
        end
    end

    // Least priority, same tie rule
    always_comb begin
        best_elem   = i_word[0].elem;
        o_prio_slot = '0;
        for (int i = 1; i < pifo_pkg::SLOTS; i++) begin
            if (i_word[i].elem < best_elem) begin
                best_elem   = i_word[i].elem;
                o_prio_slot = pifo_pkg::slot_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pifo_pkg.sv ====
`default_nettype none

package pifo_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int PRIO_W      = 16;
    localparam int CNT_W       = 10;
    localparam int SLOTS       = 8;
    localparam int SLOT_IDX_W  = 3;
    localparam int NODE_ADDR_W = 9;
    localparam int LEVEL_W     = 2;

    typedef logic [PRIO_W-1:0]      elem_t;       // All ones marks an empty slot
    typedef logic [CNT_W-1:0]       count_t;
    typedef logic [SLOT_IDX_W-1:0]  slot_idx_t;
    typedef logic [NODE_ADDR_W-1:0] node_addr_t;  // Also the SRAM address
    typedef logic [LEVEL_W-1:0]     level_t;

    // ------------------------------------------------------------------
    // Node word layout
    // ------------------------------------------------------------------
    typedef struct packed {
        count_t count;  // Elements held in the sub-tree below this slot
        elem_t  elem;
    } slot_t;

    // Slot 7 sits in the top bits of the SRAM word
    typedef slot_t [SLOTS-1:0] node_word_t;

    typedef struct packed {
        logic       push;
        logic       pop;
        elem_t      elem;   // Element pushed down
        node_addr_t addr;   // Child node address
        level_t     level;
    } child_req_t;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        PUSH = 2'b01,
        POP  = 2'b11,
        WB   = 2'b10
    } level_state_e;

endpackage

`default_nettype wire

// ==== verilog/pifo_pop_update.sv ====
`default_nettype none

module pifo_pop_update (
    input  wire pifo_pkg::node_word_t i_word,
    input  wire pifo_pkg::slot_idx_t  i_slot,
    input  wire pifo_pkg::elem_t      i_child_elem,
    output pifo_pkg::elem_t           o_elem,
    output pifo_pkg::node_word_t      o_word
);

    pifo_pkg::count_t slot_count;

    assign slot_count = i_word[i_slot].count;
    assign o_elem     = i_word[i_slot].elem;  // Smallest element leaves the node

    // Refill from the child only when the sub-tree holds something
    always_comb begin
        o_word = i_word;
        if (slot_count != '0) begin
            o_word[i_slot].count = slot_count - pifo_pkg::count_t'(1);
            o_word[i_slot].elem  = i_child_elem;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pifo_push_update.sv ====
`default_nettype none

module pifo_push_update (
    input  wire pifo_pkg::node_word_t i_word,
    input  wire pifo_pkg::slot_idx_t  i_slot,
    input  wire pifo_pkg::elem_t      i_elem,
    output pifo_pkg::node_word_t      o_word,
    output logic                      o_fwd_valid,
    output pifo_pkg::elem_t           o_fwd_elem
);

    pifo_pkg::elem_t  stored_elem;
    pifo_pkg::count_t stored_count;
    logic             slot_empty;

    assign stored_elem  = i_word[i_slot].elem;
    assign stored_count = i_word[i_slot].count;
    assign slot_empty   = (stored_elem == '1);

    // ------------------------------------------------------------------
    // Place the new element, push the larger one down
    // ------------------------------------------------------------------
    always_comb begin
        o_word              = i_word;
        o_word[i_slot].count = stored_count + pifo_pkg::count_t'(1);
        o_fwd_valid         = 1'b0;
        o_fwd_elem          = '1;

        if (slot_empty) begin
            o_word[i_slot].elem = i_elem;   // Free slot takes it directly
        end else begin
            o_fwd_valid = 1'b1;
            if (i_elem < stored_elem) begin
                // New element beats the resident one
                o_word[i_slot].elem = i_elem;
                o_fwd_elem          = stored_elem;
            end else begin
                o_fwd_elem = i_elem;    // Ties keep the resident
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pifo_sram_level.sv ====
`default_nettype none

module pifo_sram_level #(
    parameter int NUM_LEVELS = 4
) (
    input  wire                       i_clk,
    input  wire                       i_arst_n,

    // Parent
    input  wire                       i_push,
    input  wire pifo_pkg::elem_t      i_push_data,
    input  wire                       i_pop,
    input  wire pifo_pkg::node_addr_t i_my_addr,
    input  wire pifo_pkg::level_t     i_level,
    output pifo_pkg::elem_t           o_pop_data,

    // SRAM
    output logic                      o_read,
    output pifo_pkg::node_addr_t      o_read_addr,
    input  wire pifo_pkg::node_word_t i_read_data,
    output logic                      o_write,
    output pifo_pkg::node_addr_t      o_write_addr,
    output pifo_pkg::node_word_t      o_write_data,

    // Child
    output pifo_pkg::child_req_t      o_child,
    input  wire pifo_pkg::elem_t      i_pop_data
);

    pifo_pkg::node_word_t sel_word;
    pifo_pkg::slot_idx_t  count_slot;
    pifo_pkg::slot_idx_t  prio_slot;
    pifo_pkg::elem_t      push_elem;
    pifo_pkg::node_word_t push_word;
    logic                 fwd_valid;
    pifo_pkg::elem_t      fwd_elem;
    pifo_pkg::elem_t      pop_elem;
    pifo_pkg::node_word_t pop_word;

    pifo_level_ctrl #(
        .NUM_LEVELS (NUM_LEVELS)
    ) u_ctrl (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_push       (i_push),
        .i_push_data  (i_push_data),
        .i_pop        (i_pop),
        .i_my_addr    (i_my_addr),
        .i_level      (i_level),
        .i_read_data  (i_read_data),
        .i_count_slot (count_slot),
        .i_prio_slot  (prio_slot),
        .i_push_word  (push_word),
        .i_fwd_valid  (fwd_valid),
        .i_fwd_elem   (fwd_elem),
        .i_pop_elem   (pop_elem),
        .i_pop_word   (pop_word),
        .o_sel_word   (sel_word),
        .o_push_elem  (push_elem),
        .o_read       (o_read),
        .o_read_addr  (o_read_addr),
        .o_write      (o_write),
        .o_write_addr (o_write_addr),
        .o_write_data (o_write_data),
        .o_pop_data   (o_pop_data),
        .o_child      (o_child)
    );

    pifo_min_select u_min_select (
        .i_word       (sel_word),
        .o_count_slot (count_slot),
        .o_prio_slot  (prio_slot)
    );

    pifo_push_update u_push_update (
        .i_word      (sel_word),
        .i_slot      (count_slot),
        .i_elem      (push_elem),
        .o_word      (push_word),
        .o_fwd_valid (fwd_valid),
        .o_fwd_elem  (fwd_elem)
    );

    pifo_pop_update u_pop_update (
        .i_word       (sel_word),
        .i_slot       (prio_slot),
        .i_child_elem (i_pop_data),
        .o_elem       (pop_elem),
        .o_word       (pop_word)
    );

endmodule

`default_nettype wire
